//--- dcache_data_stage.f
+incdir+verif
logic/dcache_pkg.sv
logic/way_hit_check.sv
logic/line_data_array.sv
logic/store_align.sv
logic/access_resolve.sv
logic/dcache_data_stage.sv
verif/dcache_data_stage_tb.sv

//--- logic/access_resolve.sv
////////////////////////////////////////////////////////////
// Access resolve
// Miss, store and LRU requests plus the writeback response
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module access_resolve(
	input                                 clk,
	input                                 reset,
	input                                 req_valid,
	input dcache_pkg::dcache_request_t    req,
	input                                 hit,
	input [7:0]                           hit_way,
	input                                 unaligned,
	input dcache_pkg::byte_mask_t         byte_mask,
	input dcache_pkg::cache_line_data_t   store_data,
	input dcache_pkg::cache_line_data_t   load_data,
	output logic                          cache_miss,
	output dcache_pkg::miss_request_t     miss,
	output logic                          store_en,
	output dcache_pkg::store_request_t    store,
	output logic                          lru_update_en,
	output logic [7:0]                    lru_way,
	output logic                          resp_valid,
	output dcache_pkg::dcache_response_t  resp);

	dcache_pkg::thread_idx_t resp_thread;
	logic resp_rollback;
	logic resp_fault;
	logic resp_load_hit;

	assign cache_miss = req_valid && req.is_load && !hit && !unaligned;
	assign miss.addr = {req.addr.tag, req.addr.set_idx, {dcache_pkg::OFFSET_WIDTH{1'b0}}};
	assign miss.thread_idx = req.thread_idx;

	// An empty block mask writes nothing
	assign store_en = req_valid && !req.is_load && !unaligned && |byte_mask;
	assign store = '{addr: req.addr, byte_mask: byte_mask, data: store_data,
		thread_idx: req.thread_idx};

	assign lru_update_en = req_valid && hit && !unaligned;
	assign lru_way = hit_way;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			resp_valid <= 1'b0;
			resp_thread <= '0;
			resp_rollback <= 1'b0;
			resp_fault <= 1'b0;
			resp_load_hit <= 1'b0;
		end
		else
		begin
			resp_valid <= req_valid;
			resp_thread <= req.thread_idx;
			resp_rollback <= req_valid && req.is_load && !hit;
			resp_fault <= req_valid && unaligned;
			resp_load_hit <= req_valid && req.is_load && hit;
		end
	end

	// Array output lines up with the registered flags
	assign resp = '{thread_idx: resp_thread, load_data: resp_load_hit ? load_data : '0,
		rollback: resp_rollback, access_fault: resp_fault};

	// Scalar stores write one, two or four bytes
	scalar_mask_a: assert property (@(posedge clk) disable iff (reset)
		store_en && req.access != dcache_pkg::MEM_BLOCK
		|-> $countones(byte_mask) inside {1, 2, 4})
		else $error("scalar store with a malformed byte mask");

endmodule

//--- logic/dcache_data_stage.sv
////////////////////////////////////////////////////////////
// L1 data cache data stage
// Way hit detection, line read, store formatting and the
// miss, store, LRU and writeback requests
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module dcache_data_stage #(
	parameter int NUM_WAYS = dcache_pkg::DEFAULT_WAYS
)(
	input                                 clk,
	input                                 reset,

	// From tag stage
	input                                 req_valid,
	input dcache_pkg::dcache_request_t    req,
	input [NUM_WAYS - 1:0]                way_valid,
	input dcache_pkg::l1d_tag_t           way_tag[NUM_WAYS],

	// From L2 interface
	input                                 fill_en,
	input dcache_pkg::l1d_fill_t          fill,

	// To L2 interface
	output logic                          cache_miss,
	output dcache_pkg::miss_request_t     miss,
	output logic                          store_en,
	output dcache_pkg::store_request_t    store,

	// To tag stage
	output logic                          lru_update_en,
	output logic [7:0]                    lru_way,

	// To writeback stage
	output logic                          resp_valid,
	output dcache_pkg::dcache_response_t  resp);

	logic hit;
	logic [7:0] hit_way;
	logic read_en;
	logic unaligned;
	dcache_pkg::byte_mask_t byte_mask;
	dcache_pkg::cache_line_data_t store_data;
	dcache_pkg::cache_line_data_t load_data;

	way_hit_check #(.NUM_WAYS(NUM_WAYS)) way_hit_check_inst(.*);

	line_data_array #(.NUM_WAYS(NUM_WAYS)) line_data_array_inst(
		.clk(clk),
		.read_en(read_en),
		.read_way(hit_way),
		.read_set(req.addr.set_idx),
		.fill_en(fill_en),
		.fill(fill),
		.read_data(load_data));

	store_align store_align_inst(.*);

	access_resolve access_resolve_inst(.*);

endmodule

//--- logic/dcache_pkg.sv
////////////////////////////////////////////////////////////
// L1 data cache definitions
// Geometry, address fields, access kinds and the structs
// passed between the data stage and its neighbours
////////////////////////////////////////////////////////////
package dcache_pkg;

	localparam int CACHE_LINE_BYTES = 16;
	localparam int CACHE_LINE_WORDS = CACHE_LINE_BYTES / 4;
	localparam int L1D_SETS = 16;
	localparam int DEFAULT_WAYS = 4;

	localparam int OFFSET_WIDTH = $clog2(CACHE_LINE_BYTES);
	localparam int SET_IDX_WIDTH = $clog2(L1D_SETS);
	localparam int TAG_WIDTH = 32 - SET_IDX_WIDTH - OFFSET_WIDTH;

	typedef logic [31:0] scalar_t;
	typedef logic [CACHE_LINE_BYTES * 8 - 1:0] cache_line_data_t;
	typedef logic [CACHE_LINE_WORDS - 1:0] lane_mask_t;
	typedef logic [CACHE_LINE_BYTES - 1:0] byte_mask_t;
	typedef logic [TAG_WIDTH - 1:0] l1d_tag_t;
	typedef logic [SET_IDX_WIDTH - 1:0] l1d_set_idx_t;
	typedef logic [1:0] thread_idx_t;

	typedef enum logic [1:0] {MEM_B, MEM_S, MEM_L, MEM_BLOCK} mem_access_t;

	typedef struct packed {l1d_tag_t tag; l1d_set_idx_t set_idx;
		logic [OFFSET_WIDTH - 1:0] offset;} l1d_addr_t;

	// Lane i carries line word i
	typedef struct packed {scalar_t lane3; scalar_t lane2; scalar_t lane1;
		scalar_t lane0;} vector_t;

	typedef struct packed {logic is_load; mem_access_t access; thread_idx_t thread_idx;
		l1d_addr_t addr; lane_mask_t lane_mask; vector_t store_value;} dcache_request_t;

	// Way index is wide so the way count can change
	typedef struct packed {logic [7:0] way; l1d_set_idx_t set_idx;
		cache_line_data_t data;} l1d_fill_t;

	typedef struct packed {scalar_t addr; thread_idx_t thread_idx;} miss_request_t;

	typedef struct packed {scalar_t addr; byte_mask_t byte_mask; cache_line_data_t data;
		thread_idx_t thread_idx;} store_request_t;

	typedef struct packed {thread_idx_t thread_idx; cache_line_data_t load_data;
		logic rollback; logic access_fault;} dcache_response_t;

endpackage

//--- logic/line_data_array.sv
////////////////////////////////////////////////////////////
// Line data array
// One line per way and set, written by L2 fills
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module line_data_array #(
	parameter int NUM_WAYS = 4
)(
	input                                clk,
	input                                read_en,
	input [7:0]                          read_way,
	input dcache_pkg::l1d_set_idx_t      read_set,
	input                                fill_en,
	input dcache_pkg::l1d_fill_t         fill,
	output dcache_pkg::cache_line_data_t read_data);

	localparam int WAY_WIDTH = NUM_WAYS > 1 ? $clog2(NUM_WAYS) : 1;
	localparam int ADDR_WIDTH = WAY_WIDTH + dcache_pkg::SET_IDX_WIDTH;

	dcache_pkg::cache_line_data_t lines[NUM_WAYS * dcache_pkg::L1D_SETS];
	logic [ADDR_WIDTH - 1:0] read_addr;
	logic [ADDR_WIDTH - 1:0] fill_addr;

	// Way selects the block of sets
	assign read_addr = {read_way[WAY_WIDTH - 1:0], read_set};
	assign fill_addr = {fill.way[WAY_WIDTH - 1:0], fill.set_idx};

	always_ff @(posedge clk)
	begin
		if (fill_en)
			lines[fill_addr] <= fill.data;

		// Read during fill of the same entry sees the new line
		if (read_en)
		begin
			if (fill_en && fill_addr == read_addr)
				read_data <= fill.data;
			else
				read_data <= lines[read_addr];
		end
	end

	fill_way_range_a: assert property (@(posedge clk) fill_en |-> fill.way < NUM_WAYS)
		else $error("fill way out of range");

endmodule

//--- logic/store_align.sv
////////////////////////////////////////////////////////////
// Store alignment
// Byte mask, line-positioned store data and the
// misalignment check for each access kind
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module store_align(
	input dcache_pkg::dcache_request_t    req,
	output dcache_pkg::byte_mask_t        byte_mask,
	output dcache_pkg::cache_line_data_t  store_data,
	output logic                          unaligned);

	localparam int WORDS = dcache_pkg::CACHE_LINE_WORDS;
	localparam int BYTES = dcache_pkg::CACHE_LINE_BYTES;

	dcache_pkg::scalar_t [WORDS - 1:0] lanes;
	dcache_pkg::scalar_t [WORDS - 1:0] swapped;
	dcache_pkg::cache_line_data_t block_data;
	dcache_pkg::lane_mask_t word_mask;
	logic [3:0] word_byte_mask;

	assign lanes = req.store_value;

	// Little-endian scalars, offset 0 is the top byte of the line
	genvar w;
	genvar b;
	generate
		for (w = 0; w < WORDS; w++)
		begin : swap_gen
			assign swapped[w] = {lanes[w][7:0], lanes[w][15:8], lanes[w][23:16],
				lanes[w][31:24]};
			assign block_data[BYTES * 8 - 1 - 32 * w -: 32] = swapped[w];

			for (b = 0; b < 4; b++)
			begin : mask_gen
				assign byte_mask[BYTES - 1 - (4 * w + b)] = word_mask[w] & word_byte_mask[b];
			end
		end
	endgenerate

	// Word select, scalars use the offset word
	always_comb
	begin
		word_mask = '0;
		if (req.access == dcache_pkg::MEM_BLOCK)
			word_mask = req.lane_mask;
		else
			word_mask[req.addr.offset[3:2]] = 1'b1;
	end

	// Bit b of word_byte_mask is byte b of the word in address order
	always_comb
	begin
		case (req.access)
			dcache_pkg::MEM_B:
			begin
				word_byte_mask = 4'b0001 << req.addr.offset[1:0];
				store_data = {BYTES{lanes[0][7:0]}};
			end

			dcache_pkg::MEM_S:
			begin
				word_byte_mask = req.addr.offset[1] ? 4'b1100 : 4'b0011;
				store_data = {BYTES / 2{lanes[0][7:0], lanes[0][15:8]}};
			end

			dcache_pkg::MEM_L:
			begin
				word_byte_mask = 4'b1111;
				store_data = {WORDS{swapped[0]}};
			end

			default:
			begin
				word_byte_mask = 4'b1111;
				store_data = block_data;
			end
		endcase
	end

	always_comb
	begin
		case (req.access)
			dcache_pkg::MEM_S: unaligned = req.addr.offset[0];
			dcache_pkg::MEM_L: unaligned = |req.addr.offset[1:0];
			dcache_pkg::MEM_BLOCK: unaligned = |req.addr.offset;
			default: unaligned = 1'b0;
		endcase
	end

endmodule

//--- logic/way_hit_check.sv
////////////////////////////////////////////////////////////
// Way hit check
// Matches the request tag against every valid way
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module way_hit_check #(
	parameter int NUM_WAYS = 4
)(
	input                               req_valid,
	input dcache_pkg::dcache_request_t  req,
	input [NUM_WAYS - 1:0]              way_valid,
	input dcache_pkg::l1d_tag_t         way_tag[NUM_WAYS],
	output logic                        hit,
	output logic [7:0]                  hit_way,
	output logic                        read_en);

	logic [NUM_WAYS - 1:0] hit_oh;

	genvar way_idx;
	generate
		for (way_idx = 0; way_idx < NUM_WAYS; way_idx++)
		begin : tag_cmp_gen
			assign hit_oh[way_idx] = way_valid[way_idx]
				&& way_tag[way_idx] == req.addr.tag;
		end
	endgenerate

	// One-hot to index, relies on at most one way hitting
	always_comb
	begin
		hit_way = '0;
		for (int i = 0; i < NUM_WAYS; i++)
		begin
			if (hit_oh[i])
				hit_way = 8'(i);
		end
	end

	assign hit = |hit_oh;

	// Only a load hit needs the line from the data array
	assign read_en = req_valid && req.is_load && hit;

	// The tag stage must never hold the same line in two ways
	hit_onehot_a: assert final (!req_valid || $onehot0(hit_oh))
		else $error("line present in more than one way");

endmodule

//--- verif/dcache_vectors.svh
////////////////////////////////////////////////////////////
// Data stage test table
// One row per test with the fill, the request and the
// expected enables, byte mask and response flags
////////////////////////////////////////////////////////////
`ifndef DCACHE_VECTORS_SVH
`define DCACHE_VECTORS_SVH

// Way w holds tag TAG_BASE + w
localparam logic [23:0] TAG_BASE = 24'hABC120;

localparam logic [1:0] AK_B = dcache_pkg::MEM_B;
localparam logic [1:0] AK_S = dcache_pkg::MEM_S;
localparam logic [1:0] AK_L = dcache_pkg::MEM_L;
localparam logic [1:0] AK_BLK = dcache_pkg::MEM_BLOCK;

typedef struct packed {
	logic [8 * 12 - 1:0] name;
	logic fill_en;
	logic [7:0] fill_way;
	logic [7:0] fill_gen;
	logic req_valid;
	logic is_load;
	logic [1:0] access;
	logic [1:0] thread;
	logic [31:0] addr;
	logic [3:0] lane_mask;
	logic [3:0] way_valid;
	// miss, store, lru, rollback, fault
	logic [4:0] flags;
	logic [7:0] hit_way;
	logic [15:0] mask;
} test_vector_t;

localparam int NUM_TESTS = 22;

// name, fill_en, fill_way, fill_gen, req_valid, is_load, access, thread,
// addr, lane_mask, way_valid, flags, hit_way, mask
test_vector_t vectors[NUM_TESTS] = '{
	'{"fill_w2",    1, 2, 1, 0, 0, AK_L,   0, 'hABC12250, 0, 'hF, 'b00000, 0, 0},
	'{"hit_w2",     0, 0, 0, 1, 1, AK_L,   1, 'hABC12250, 0, 'hF, 'b00100, 2, 0},
	'{"miss_tag",   0, 0, 0, 1, 1, AK_B,   3, 'hABC12977, 0, 'hF, 'b10010, 0, 0},
	'{"miss_inval", 0, 0, 0, 1, 1, AK_S,   2, 'hABC1225A, 0, 'hB, 'b10010, 0, 0},
	'{"st_b_0",     0, 0, 0, 1, 0, AK_B,   0, 'hABC12330, 0, 0, 'b01000, 0, 'h8000},
	'{"st_b_5",     0, 0, 0, 1, 0, AK_B,   1, 'hABC12335, 0, 0, 'b01000, 0, 'h0400},
	'{"st_b_10",    0, 0, 0, 1, 0, AK_B,   2, 'hABC1233A, 0, 0, 'b01000, 0, 'h0020},
	'{"st_b_15",    0, 0, 0, 1, 0, AK_B,   3, 'hABC1233F, 0, 0, 'b01000, 0, 'h0001},
	'{"st_h_0",     0, 0, 0, 1, 0, AK_S,   0, 'hABC12340, 0, 0, 'b01000, 0, 'hC000},
	'{"st_h_6",     0, 0, 0, 1, 0, AK_S,   1, 'hABC12346, 0, 0, 'b01000, 0, 'h0300},
	'{"st_h_10",    0, 0, 0, 1, 0, AK_S,   2, 'hABC1234A, 0, 0, 'b01000, 0, 'h0030},
	'{"st_h_14",    0, 0, 0, 1, 0, AK_S,   3, 'hABC1234E, 0, 0, 'b01000, 0, 'h0003},
	'{"st_w_0",     0, 0, 0, 1, 0, AK_L,   0, 'hABC12350, 0, 0, 'b01000, 0, 'hF000},
	'{"st_w_4",     0, 0, 0, 1, 0, AK_L,   1, 'hABC12354, 0, 0, 'b01000, 0, 'h0F00},
	'{"st_w_8",     0, 0, 0, 1, 0, AK_L,   2, 'hABC12358, 0, 0, 'b01000, 0, 'h00F0},
	'{"st_w_12",    0, 0, 0, 1, 0, AK_L,   3, 'hABC1235C, 0, 0, 'b01000, 0, 'h000F},
	'{"blk_0101",   0, 0, 0, 1, 0, AK_BLK, 1, 'hABC12360, 'h5, 0, 'b01000, 0, 'hF0F0},
	'{"blk_0000",   0, 0, 0, 1, 0, AK_BLK, 2, 'hABC12370, 'h0, 0, 'b00000, 0, 0},
	'{"mis_h",      0, 0, 0, 1, 0, AK_S,   0, 'hABC12383, 0, 0, 'b00001, 0, 0},
	'{"mis_w",      0, 0, 0, 1, 1, AK_L,   3, 'hABC12256, 0, 'hF, 'b00001, 2, 0},
	'{"mis_blk",    0, 0, 0, 1, 0, AK_BLK, 1, 'hABC12384, 'hF, 0, 'b00001, 0, 0},
	'{"fill_hit",   1, 2, 2, 1, 1, AK_L,   2, 'hABC12250, 0, 'hF, 'b00100, 2, 0}
};

`endif

//--- verif/dcache_data_stage_tb.sv
////////////////////////////////////////////////////////////
// Data stage testbench
// Applies the test table and checks the request pulses
// and the registered response
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module dcache_data_stage_tb;

	`include "dcache_vectors.svh"

	localparam int CYCLE_LIMIT = 16 + 3 * NUM_TESTS + 20;

	logic clk = 1'b0;
	logic reset;
	logic req_valid;
	dcache_pkg::dcache_request_t req;
	logic [3:0] way_valid;
	dcache_pkg::l1d_tag_t way_tag[4];
	logic fill_en;
	dcache_pkg::l1d_fill_t fill;
	logic cache_miss;
	dcache_pkg::miss_request_t miss;
	logic store_en;
	dcache_pkg::store_request_t store;
	logic lru_update_en;
	logic [7:0] lru_way;
	logic resp_valid;
	dcache_pkg::dcache_response_t resp;

	dcache_pkg::cache_line_data_t shadow[4][16];
	logic [15:0] lfsr_state = 16'd27485;
	int cycle_count = 0;
	int error_count = 0;
	int pass_count = 0;
	int fail_count = 0;

	dcache_data_stage #(.NUM_WAYS(4)) dcache_data_stage_inst(.*);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	// Taps 16, 14, 13, 11
	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic dcache_pkg::scalar_t random_word();
		dcache_pkg::scalar_t w;
		for (int i = 0; i < 32; i++)
			w = {w[30:0], next_random_bit()};
		return w;
	endfunction

	// Every word carries the generation, way and set
	function automatic dcache_pkg::cache_line_data_t fill_line(input logic [7:0] way,
		input logic [3:0] set_idx, input logic [7:0] gen);
		dcache_pkg::cache_line_data_t line;
		for (int i = 0; i < 4; i++)
			line[32 * i +: 32] = {gen, way, 4'h5, set_idx, 8'(8'hC0 + i)};
		return line;
	endfunction

	// Byte at offset k comes from lane k/4 for blocks, from lane 0 otherwise
	function automatic dcache_pkg::cache_line_data_t expected_store_data(
		input logic [1:0] access, input logic [127:0] lanes);
		dcache_pkg::cache_line_data_t line;
		int lane;
		int lane_byte;
		for (int k = 0; k < 16; k++)
		begin
			lane = access == AK_BLK ? k / 4 : 0;
			lane_byte = access == AK_B ? 0 : (access == AK_S ? k % 2 : k % 4);
			line[8 * (15 - k) +: 8] = lanes[32 * lane + 8 * lane_byte +: 8];
		end
		return line;
	endfunction

	function automatic string name_text(input logic [8 * 12 - 1:0] raw);
		string s;
		s = "";
		for (int i = 11; i >= 0; i--)
		begin
			if (raw[8 * i +: 8] != 8'h00)
				s = $sformatf("%s%c", s, raw[8 * i +: 8]);
		end
		return s;
	endfunction

	task automatic check_value(input string test, input string what,
		input logic [127:0] expected, input logic [127:0] actual);
		if (expected !== actual)
		begin
			$display("[FAIL] %s %s: expected %h, actual %h", test, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic finish_test(input string test, input int errors_before);
		if (error_count == errors_before)
		begin
			pass_count++;
			$display("Test %s: passed", test);
		end
		else
		begin
			fail_count++;
			$display("Test %s: failed with %0d mismatches", test, error_count - errors_before);
		end
	endtask

	task automatic run_test(input int t);
		test_vector_t v;
		string name;
		logic [127:0] lanes;
		int errors_before;
		v = vectors[t];
		name = name_text(v.name);
		errors_before = error_count;
		for (int j = 0; j < 4; j++)
			lanes[32 * j +: 32] = random_word();

		@(negedge clk);
		fill_en = v.fill_en;
		fill.way = v.fill_way;
		fill.set_idx = v.addr[7:4];
		fill.data = fill_line(v.fill_way, v.addr[7:4], v.fill_gen);
		if (v.fill_en)
			shadow[v.fill_way][v.addr[7:4]] = fill.data;
		req_valid = v.req_valid;
		req.is_load = v.is_load;
		req.access = dcache_pkg::mem_access_t'(v.access);
		req.thread_idx = v.thread;
		req.addr = v.addr;
		req.lane_mask = v.lane_mask;
		req.store_value = lanes;
		way_valid = v.way_valid;
		for (int w = 0; w < 4; w++)
			way_tag[w] = TAG_BASE + w;

		// Request pulses settle well before the rising edge
		#10;
		check_value(name, "cache_miss", v.flags[4], cache_miss);
		check_value(name, "store_en", v.flags[3], store_en);
		check_value(name, "lru_update_en", v.flags[2], lru_update_en);
		if (v.flags[4])
		begin
			check_value(name, "miss addr", v.addr & 32'hFFFF_FFF0, miss.addr);
			check_value(name, "miss thread", v.thread, miss.thread_idx);
		end
		if (v.flags[3])
		begin
			check_value(name, "store addr", v.addr, store.addr);
			check_value(name, "store mask", v.mask, store.byte_mask);
			check_value(name, "store data", expected_store_data(v.access, lanes), store.data);
			check_value(name, "store thread", v.thread, store.thread_idx);
		end
		if (v.flags[2])
			check_value(name, "lru_way", v.hit_way, lru_way);

		@(negedge clk);
		check_value(name, "resp_valid", v.req_valid, resp_valid);
		if (v.req_valid)
		begin
			check_value(name, "resp thread", v.thread, resp.thread_idx);
			check_value(name, "rollback", v.flags[1], resp.rollback);
			check_value(name, "access fault", v.flags[0], resp.access_fault);
			if (v.is_load && !v.flags[1])
				check_value(name, "load data", shadow[v.hit_way][v.addr[7:4]], resp.load_data);
		end
		fill_en = 1'b0;
		req_valid = 1'b0;
		finish_test(name, errors_before);
	endtask

	initial
	begin
		int errors_before;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		way_valid = '0;
		for (int w = 0; w < 4; w++)
			way_tag[w] = '0;
		fill_en = 1'b0;
		fill = '0;

		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		errors_before = error_count;
		check_value("reset", "resp_valid", 1'b0, resp_valid);
		check_value("reset", "resp thread", '0, resp.thread_idx);
		check_value("reset", "load data", '0, resp.load_data);
		check_value("reset", "rollback", 1'b0, resp.rollback);
		check_value("reset", "access fault", 1'b0, resp.access_fault);
		finish_test("reset", errors_before);

		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);

		$display("Tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
